//--- project.f
+incdir+.
dcache_pkg.sv
dcache_tags.sv
dcache_data.sv
dcache_ctrl.sv
dcache.sv
tb_clock.sv
tb_dcache.sv

//--- Makefile
TOP = tb_dcache

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

run: build
	-./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module dcache

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- tb_dcache.sv
// Data cache testbench with memory model, reference model and checking assertions
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tb_dcache;

	import dcache_pkg::*;

	typedef struct packed {
		logic                  wr;
		logic [`DC_WORD_W-1:0] addr;
		logic [`DC_WORD_W-1:0] data;
	} xfer;

	logic   CLK;
	logic   nRST;
	cpuReq  cpuIn;
	memResp memIn;
	cpuResp cpuOut;
	memReq  memOut;

	// Memory contents, and the value the CPU should see at each word
	logic [`DC_WORD_W-1:0] mem [logic [29:0]];
	logic [`DC_WORD_W-1:0] gold [logic [29:0]];

	// Reference line state per way and set
	logic [`DC_TAG_W-1:0] refTag [2][`DC_SETS];
	logic [`DC_SETS-1:0]  refValid [2] = '{default: '0};
	logic [`DC_SETS-1:0]  refDirty [2] = '{default: '0};
	logic [`DC_SETS-1:0]  refRecent = '0;

	xfer    xferQ [$];
	xfer    expHead;
	xfer    actXfer;
	int     doneCount;
	int     pending;
	logic   xferNow;
	logic   started;
	logic   expHit;
	logic   flushedSeen;
	logic   cmpOn;
	logic [`DC_WORD_W-1:0] expLoad;
	logic [`DC_WORD_W-1:0] cmpExp;
	logic [`DC_WORD_W-1:0] cmpAct;
	string  testName;
	integer seed = 32'hcabf_7cc3;

	tb_clock i_clock (.CLK, .nRST);

	dcache i_dcache (.CLK, .nRST, .cpuIn, .memIn, .cpuOut, .memOut);

	function automatic logic [`DC_WORD_W-1:0] fillWord(input logic [29:0] w);
		return {w[15:0], w[29:16], 2'b11} ^ 32'hc3c3_3c3c;
	endfunction

	function automatic logic [`DC_WORD_W-1:0] memWord(input logic [29:0] w);
		return mem.exists(w) ? mem[w] : fillWord(w);
	endfunction

	function automatic logic [`DC_WORD_W-1:0] goldWord(input logic [29:0] w);
		return gold.exists(w) ? gold[w] : fillWord(w);
	endfunction

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic pushXfer(input logic wr, input logic [31:0] addr, input logic [31:0] data);
		xfer x;
		x.wr = wr;
		x.addr = addr;
		x.data = data;
		xferQ.push_back(x);
	endtask

	// Both words of a dirty line go back A then B
	task automatic queueWriteBack(input logic w, input logic [3:0] s);
		logic [31:0] base;
		base = {refTag[w][s], s, 3'b000};
		pushXfer(1'b1, base, goldWord(base[31:2]));
		pushXfer(1'b1, base + 32'(`DC_WORD_BYTES), goldWord(base[31:2] + 30'd1));
		refDirty[w][s] = 1'b0;
	endtask

	task automatic modelAccess(input logic wr, input logic [31:0] addr, input logic [31:0] data);
		logic [3:0]  s;
		logic        w;
		logic [31:0] base;
		s = addr[6:3];
		base = {addr[31:3], 3'b000};
		expHit = 1'b0;
		w = 1'b0;
		for (int i = 0; i < 2; i++) begin
			if (refValid[i][s] && refTag[i][s] == addr[31:7]) begin
				expHit = 1'b1;
				w = 1'(i);
			end
		end
		if (!expHit) begin
			// Invalid way first, way 0 preferred, else the way not recently used
			if (!refValid[0][s] || !refValid[1][s]) begin
				w = refValid[0][s];
			end else begin
				w = ~refRecent[s];
			end
			if (refValid[w][s] && refDirty[w][s]) begin
				queueWriteBack(w, s);
			end
			pushXfer(1'b0, base, '0);
			pushXfer(1'b0, base + 32'(`DC_WORD_BYTES), '0);
			refTag[w][s] = addr[31:7];
			refValid[w][s] = 1'b1;
		end
		if (wr) begin
			gold[addr[31:2]] = data;
			refDirty[w][s] = 1'b1;
		end
		refRecent[s] = w;
		expLoad = goldWord(addr[31:2]);
	endtask

	// Request held until the hit pulse, then dropped
	task automatic runAccess(input logic wr, input logic [31:0] addr, input logic [31:0] data);
		int cycles;
		modelAccess(wr, addr, data);
		cpuIn.ren = !wr;
		cpuIn.wen = wr;
		cpuIn.addr = addr;
		cpuIn.store = data;
		started = 1'b1;
		cycles = 0;
		while (!cpuOut.hit && cycles < 200) begin
			@(posedge CLK);
			#1;
			started = 1'b0;
			cycles++;
		end
		if (!cpuOut.hit) begin
			failRun($sformatf("%s timed out waiting for hit at address %h", testName, addr));
		end
		@(posedge CLK);
		#1;
		cpuIn.ren = 1'b0;
		cpuIn.wen = 1'b0;
	endtask

	assign xferNow = (memOut.ren || memOut.wen) && !memIn.memWait;
	assign actXfer = {memOut.wen, memOut.addr, memOut.wen ? memOut.store : 32'h0};

	// Memory model with random wait
	initial begin
		memIn = '0;
		doneCount = 0;
		pending = 0;
		expHead = '0;
		forever begin
			@(posedge CLK);
			if (xferNow) begin
				if (memOut.wen) begin
					mem[memOut.addr[31:2]] = memOut.store;
				end
				doneCount++;
			end
			pending = xferQ.size() - doneCount;
			expHead = (pending > 0) ? xferQ[doneCount] : '0;
			#1;
			memIn.memWait = (($random(seed) & 32'h3) == 32'h0);
			memIn.load = memWord(memOut.addr[31:2]);
		end
	end

	assert property (@(posedge CLK) disable iff (!nRST) xferNow |-> pending > 0)
		else failRun($sformatf("%s unexpected memory transfer at %h", testName, memOut.addr));
	assert property (@(posedge CLK) disable iff (!nRST) xferNow |-> actXfer == expHead)
		else failRun($sformatf("Mismatch %s transfer: expected %h actual %h",
			testName, expHead, actXfer));
	assert property (@(posedge CLK) disable iff (!nRST)
		(memOut.ren || memOut.wen) && memIn.memWait |=> $stable(memOut))
		else failRun($sformatf("%s memory request changed while wait was high", testName));
	assert property (@(posedge CLK) disable iff (!nRST) cpuOut.hit |-> pending == 0)
		else failRun($sformatf("%s hit came before all memory transfers", testName));
	assert property (@(posedge CLK) disable iff (!nRST)
		cpuOut.hit && cpuIn.ren |-> cpuOut.load == expLoad)
		else failRun($sformatf("Mismatch %s load: expected %h actual %h",
			testName, expLoad, cpuOut.load));
	assert property (@(posedge CLK) disable iff (!nRST)
		started && expHit && cpuIn.ren |=> cpuOut.hit)
		else failRun($sformatf("%s read hit did not answer in one cycle", testName));
	assert property (@(posedge CLK) disable iff (!nRST)
		started && expHit && cpuIn.wen |=> !cpuOut.hit ##1 cpuOut.hit)
		else failRun($sformatf("%s write hit did not answer in two cycles", testName));
	assert property (@(posedge CLK) disable iff (!nRST) flushedSeen |-> cpuOut.flushed)
		else failRun("flushed dropped after the flush finished");
	assert property (@(posedge CLK) disable iff (!nRST) cpuOut.flushed |-> pending == 0)
		else failRun("flushed rose before every dirty block was written back");
	assert property (@(posedge CLK) disable iff (!nRST) cmpOn |-> cmpAct == cmpExp)
		else failRun($sformatf("Mismatch %s memory: expected %h actual %h",
			testName, cmpExp, cmpAct));

	initial begin
		logic [31:0] a;
		logic [31:0] d;
		logic [29:0] k;
		int          cycles;
		cpuIn = '0;
		started = 1'b0;
		expHit = 1'b0;
		flushedSeen = 1'b0;
		cmpOn = 1'b0;
		expLoad = '0;
		cmpExp = '0;
		cmpAct = '0;
		testName = "reset";
		cycles = 0;
		while (!nRST && cycles < 10) begin
			@(posedge CLK);
			cycles++;
		end
		if (!nRST) begin
			failRun("reset was never released");
		end
		#1;
		testName = "readMissHit";
		runAccess(1'b0, 32'h0000_0100, '0);
		runAccess(1'b0, 32'h0000_0104, '0);
		runAccess(1'b0, 32'h0000_0100, '0);
		testName = "writeAllocate";
		runAccess(1'b1, 32'h0000_0208, 32'h1111_2222);
		runAccess(1'b1, 32'h0000_020c, 32'h3333_4444);
		runAccess(1'b0, 32'h0000_0208, '0);
		// Tags X, Y and Z all in set 5
		testName = "replacement";
		runAccess(1'b0, 32'h0000_00a8, '0);
		runAccess(1'b0, 32'h0000_0128, '0);
		runAccess(1'b0, 32'h0000_00a8, '0);
		runAccess(1'b0, 32'h0000_01a8, '0);
		runAccess(1'b0, 32'h0000_00ac, '0);
		runAccess(1'b0, 32'h0000_0128, '0);
		testName = "dirtyWriteBack";
		runAccess(1'b1, 32'h0000_0448, 32'hdead_0001);
		runAccess(1'b1, 32'h0000_04cc, 32'hdead_0002);
		runAccess(1'b0, 32'h0000_0548, '0);
		runAccess(1'b0, 32'h0000_05cc, '0);
		testName = "randomMix";
		for (int i = 0; i < 60; i++) begin
			a = $random(seed) & 32'h0000_07fc;
			d = $random(seed);
			runAccess(d[0], a, d);
		end
		// Expected flush order is way 0 from set 0 up, then way 1
		testName = "flush";
		for (int i = 0; i < 2; i++) begin
			for (int s = 0; s < `DC_SETS; s++) begin
				if (refValid[i][s] && refDirty[i][s]) begin
					queueWriteBack(1'(i), 4'(s));
				end
			end
		end
		cpuIn.halt = 1'b1;
		cycles = 0;
		while (!cpuOut.flushed && cycles < 2000) begin
			@(posedge CLK);
			#1;
			cycles++;
		end
		if (!cpuOut.flushed) begin
			failRun("timed out waiting for the flush to finish");
		end
		flushedSeen = 1'b1;
		if (gold.first(k)) begin
			do begin
				cmpExp = gold[k];
				cmpAct = memWord(k);
				cmpOn = 1'b1;
				@(posedge CLK);
				#1;
			end while (gold.next(k));
		end
		cmpOn = 1'b0;
		@(posedge CLK);
		#1;
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- tb_clock.sv
// Testbench clock with a 20 ns period and an active-low reset held for two cycles
`timescale 1ns/1ps

module tb_clock (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever begin
			#10 CLK = ~CLK;
		end
	end

	initial begin
		nRST = 1'b0;
		repeat (2) @(posedge CLK);
		#1 nRST = 1'b1;
	end

endmodule

//--- dcache.sv
// Data cache top, tags and data arrays steered by the controller
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache (
	input  logic               CLK,
	input  logic               nRST,
	input  dcache_pkg::cpuReq  cpuIn,
	input  dcache_pkg::memResp memIn,
	output dcache_pkg::cpuResp cpuOut,
	output dcache_pkg::memReq  memOut
);

	import dcache_pkg::*;

	tagWrite               cmd;
	dcacheAddr             curAddr;

	logic                  hit;
	logic                  hitWay;
	logic                  victimWay;
	logic                  victimDirty;
	logic                  anyDirty;
	logic                  flushWay;
	logic [`DC_TAG_W-1:0]  victimTag;
	logic [`DC_IDX_W-1:0]  flushIdx;

	logic                  way;
	logic                  wordSel;
	logic                  wen;
	logic [`DC_WORD_W-1:0] wdata;
	logic [`DC_WORD_W-1:0] rword;
	logic [`DC_WORD_W-1:0] blockA;
	logic [`DC_WORD_W-1:0] blockB;

	dcacheTags i_tags (
		.CLK, .nRST,
		.reqAddr (curAddr),
		.cmd,
		.hit, .hitWay, .victimWay, .victimDirty, .anyDirty,
		.flushWay, .victimTag, .flushIdx
	);

	dcacheData i_data (
		.CLK, .nRST,
		.way, .wordSel, .wen,
		.set (curAddr.parts.idx),
		.wdata, .rword, .blockA, .blockB
	);

	dcacheCtrl i_ctrl (
		.CLK, .nRST,
		.req   (cpuIn),
		.mresp (memIn),
		.hit, .hitWay, .victimWay, .victimDirty, .anyDirty,
		.flushWay, .victimTag, .flushIdx,
		.rword, .blockA, .blockB,
		.resp  (cpuOut),
		.mreq  (memOut),
		.cmd, .curAddr, .way, .wordSel, .wen, .wdata
	);

endmodule

//--- dcache_ctrl.sv
// Cache controller FSM for hits, refill, write-back, flush and memory handshake
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcacheCtrl (
	input  logic                  CLK,
	input  logic                  nRST,
	input  dcache_pkg::cpuReq     req,
	input  dcache_pkg::memResp    mresp,
	input  logic                  hit,
	input  logic                  hitWay,
	input  logic                  victimWay,
	input  logic                  victimDirty,
	input  logic                  anyDirty,
	input  logic                  flushWay,
	input  logic [`DC_TAG_W-1:0]  victimTag,
	input  logic [`DC_IDX_W-1:0]  flushIdx,
	input  logic [`DC_WORD_W-1:0] rword,
	input  logic [`DC_WORD_W-1:0] blockA,
	input  logic [`DC_WORD_W-1:0] blockB,
	output dcache_pkg::cpuResp    resp,
	output dcache_pkg::memReq     mreq,
	output dcache_pkg::tagWrite   cmd,
	output dcache_pkg::dcacheAddr curAddr,
	output logic                  way,
	output logic                  wordSel,
	output logic                  wen,
	output logic [`DC_WORD_W-1:0] wdata
);

	import dcache_pkg::*;

	ctrlState  state;
	ctrlState  nextState;

	// Way picked in idle, held through the miss or the hit
	logic      tgtWay;
	logic      flushMode;

	dcacheAddr fillBase;
	dcacheAddr cleanBase;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state     <= stIdle;
			tgtWay    <= 1'b0;
			flushMode <= 1'b0;
		end else begin
			state <= nextState;
			if (state == stIdle) begin
				tgtWay    <= hit ? hitWay : victimWay;
				flushMode <= req.halt;
			end
		end
	end

	// During flush the scan picks the line, not the CPU
	always_comb begin
		if (flushMode) begin
			curAddr.word = '0;
			curAddr.parts.idx = flushIdx;
		end else begin
			curAddr.word = req.addr;
		end
	end

	assign way = flushMode ? flushWay : tgtWay;

	// Block base addresses for refill and write-back
	always_comb begin
		fillBase = curAddr;
		fillBase.parts.blkoff = 1'b0;
		fillBase.parts.bytoff = '0;
		cleanBase = fillBase;
		cleanBase.parts.tag = victimTag;
	end

	always_comb begin
		nextState = state;
		case (state)
			stIdle: begin
				if (req.halt) begin
					nextState = stFlush;
				end else if (req.ren && hit) begin
					nextState = stReadHit;
				end else if (req.wen && hit) begin
					nextState = stOverwrite;
				end else if (req.ren || req.wen) begin
					nextState = victimDirty ? stCleanA : stFetchA;
				end
			end
			stReadHit:   nextState = stIdle;
			stOverwrite: nextState = stWriteHit;
			stWriteHit:  nextState = stIdle;
			stCleanA: begin
				if (!mresp.memWait) begin
					nextState = stCleanB;
				end
			end
			stCleanB: begin
				if (!mresp.memWait) begin
					nextState = flushMode ? stFlush : stFetchA;
				end
			end
			stFetchA: begin
				if (!mresp.memWait) begin
					nextState = stFetchB;
				end
			end
			stFetchB: begin
				if (!mresp.memWait) begin
					nextState = req.wen ? stOverwrite : stIdle;
				end
			end
			stFlush:  nextState = anyDirty ? stCleanA : stStop;
			stStop:   nextState = stStop;
			default:  nextState = stIdle;
		endcase
	end

	// Outputs decoded from the current state
	always_comb begin
		mreq = '0;
		cmd = '0;
		cmd.way = way;
		cmd.set = curAddr.parts.idx;
		cmd.tag = curAddr.parts.tag;
		wordSel = curAddr.parts.blkoff;
		wen = 1'b0;
		wdata = req.store;
		case (state)
			stReadHit: begin
				cmd.touch = 1'b1;
			end
			stOverwrite: begin
				wen = 1'b1;
				cmd.setDirty = 1'b1;
				cmd.touch = 1'b1;
			end
			stCleanA: begin
				mreq.wen = 1'b1;
				mreq.addr = cleanBase.word;
				mreq.store = blockA;
			end
			stCleanB: begin
				mreq.wen = 1'b1;
				mreq.addr = cleanBase.word + `DC_WORD_W'(`DC_WORD_BYTES);
				mreq.store = blockB;
				cmd.clrDirty = !mresp.memWait;
			end
			stFetchA: begin
				mreq.ren = 1'b1;
				mreq.addr = fillBase.word;
				wordSel = 1'b0;
				wdata = mresp.load;
				wen = !mresp.memWait;
			end
			stFetchB: begin
				mreq.ren = 1'b1;
				mreq.addr = fillBase.word + `DC_WORD_W'(`DC_WORD_BYTES);
				wordSel = 1'b1;
				wdata = mresp.load;
				wen = !mresp.memWait;
				// Line becomes valid and clean with its last word
				cmd.setValid = !mresp.memWait;
				cmd.clrDirty = !mresp.memWait;
			end
			default: begin
			end
		endcase
	end

	assign resp.hit = (state == stReadHit) || (state == stWriteHit);
	assign resp.load = rword;
	assign resp.flushed = (state == stStop);

	assert property (@(posedge CLK) disable iff (!nRST) !(mreq.ren && mreq.wen))
		else $error("dcacheCtrl: memory read and write together");

	// Request held steady until memory drops wait
	assert property (@(posedge CLK) disable iff (!nRST)
		(mreq.ren || mreq.wen) && mresp.memWait |=> $stable(mreq))
		else $error("dcacheCtrl: memory request changed under wait");

endmodule

//--- dcache_data.sv
// Two-way data array, two words per line, one word written per cycle
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcacheData (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  way,
	input  logic                  wordSel,
	input  logic                  wen,
	input  logic [`DC_IDX_W-1:0]  set,
	input  logic [`DC_WORD_W-1:0] wdata,
	output logic [`DC_WORD_W-1:0] rword,
	output logic [`DC_WORD_W-1:0] blockA,
	output logic [`DC_WORD_W-1:0] blockB
);

	// Indexed by way, set, then word within the block
	logic [`DC_WORD_W-1:0] words [2][`DC_SETS][2];

	always_ff @(posedge CLK) begin
		if (wen) begin
			words[way][set][wordSel] <= wdata;
		end
	end

	// Word for the CPU
	assign rword = words[way][set][wordSel];

	// Whole line for write-back
	assign blockA = words[way][set][0];
	assign blockB = words[way][set][1];

	// Controller must steer a write to a known line
	assert property (@(posedge CLK) disable iff (!nRST)
		wen |-> !$isunknown({way, set, wordSel}))
		else $error("dcacheData: write with unknown way, set or word select");

endmodule

//--- dcache_tags.sv
// Tag, valid, dirty and recently-used storage with hit, victim and flush scan
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcacheTags (
	input  logic                  CLK,
	input  logic                  nRST,
	input  dcache_pkg::dcacheAddr reqAddr,
	input  dcache_pkg::tagWrite   cmd,
	output logic                  hit,
	output logic                  hitWay,
	output logic                  victimWay,
	output logic                  victimDirty,
	output logic                  anyDirty,
	output logic                  flushWay,
	output logic [`DC_TAG_W-1:0]  victimTag,
	output logic [`DC_IDX_W-1:0]  flushIdx
);

	import dcache_pkg::*;

	logic [`DC_TAG_W-1:0] tagArr [2][`DC_SETS];
	logic [`DC_SETS-1:0]  valid [2];
	logic [`DC_SETS-1:0]  dirty [2];

	// Way most recently used in each set
	logic [`DC_SETS-1:0]  recent;

	logic [`DC_IDX_W-1:0] idx;
	logic                 hit0;
	logic                 hit1;
	logic                 valid0;
	logic                 valid1;

	assign idx = reqAddr.parts.idx;

	// Tag compare in both ways
	assign valid0 = valid[0][idx];
	assign valid1 = valid[1][idx];
	assign hit0 = valid0 && (tagArr[0][idx] == reqAddr.parts.tag);
	assign hit1 = valid1 && (tagArr[1][idx] == reqAddr.parts.tag);
	assign hit = hit0 || hit1;
	assign hitWay = hit1;

	// Victim choice
	always_comb begin
		if (!valid0) begin
			victimWay = 1'b0;
		end else if (!valid1) begin
			victimWay = 1'b1;
		end else begin
			victimWay = ~recent[idx];
		end
	end

	// Dirty only ever set on a valid line
	assign victimDirty = dirty[victimWay][idx];

	// Tag of the line the controller has selected, for write-back addresses
	assign victimTag = tagArr[cmd.way][idx];

	assign anyDirty = (|dirty[0]) || (|dirty[1]);

	// Priority scan for flush
	// Walks backwards so the last match is way 0, lowest set
	always_comb begin
		flushWay = 1'b0;
		flushIdx = '0;
		for (int w = 1; w >= 0; w--) begin
			for (int s = `DC_SETS - 1; s >= 0; s--) begin
				if (dirty[w][s]) begin
					flushWay = 1'(w);
					flushIdx = `DC_IDX_W'(s);
				end
			end
		end
	end

	// Line state bits
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid  <= '{default: '0};
			dirty  <= '{default: '0};
			recent <= '0;
		end else begin
			if (cmd.setValid) begin
				valid[cmd.way][cmd.set] <= 1'b1;
			end
			if (cmd.setDirty) begin
				dirty[cmd.way][cmd.set] <= 1'b1;
			end else if (cmd.clrDirty) begin
				dirty[cmd.way][cmd.set] <= 1'b0;
			end
			if (cmd.touch) begin
				recent[cmd.set] <= cmd.way;
			end
		end
	end

	// Tags load with the valid bit on refill
	always_ff @(posedge CLK) begin
		if (cmd.setValid) begin
			tagArr[cmd.way][cmd.set] <= cmd.tag;
		end
	end

	// A block lives in at most one way of its set
	assert property (@(posedge CLK) disable iff (!nRST) !(hit0 && hit1))
		else $error("dcacheTags: both ways hit in set %0d", idx);

	// Dirty lines must be valid, otherwise flush writes back garbage
	assert property (@(posedge CLK) disable iff (!nRST)
		cmd.setDirty |=> valid[$past(cmd.way)][$past(cmd.set)])
		else $error("dcacheTags: dirty line without valid");

endmodule

//--- dcache_pkg.sv
// Data cache types for the CPU port, the memory port and the controller
`include "dcache_defines.svh"

package dcache_pkg;

	// Address split into cache fields
	typedef struct packed {
		logic [`DC_TAG_W-1:0]    tag;
		logic [`DC_IDX_W-1:0]    idx;
		logic                    blkoff;
		logic [`DC_BYTOFF_W-1:0] bytoff;
	} addrFields;

	// Same word seen as a plain value or as its fields
	typedef union packed {
		logic [`DC_WORD_W-1:0] word;
		addrFields             parts;
	} dcacheAddr;

	typedef struct packed {
		logic                  ren;
		logic                  wen;
		logic                  halt;
		logic [`DC_WORD_W-1:0] addr;
		logic [`DC_WORD_W-1:0] store;
	} cpuReq;

	typedef struct packed {
		logic                  hit;
		logic [`DC_WORD_W-1:0] load;
		logic                  flushed;
	} cpuResp;

	typedef struct packed {
		logic                  ren;
		logic                  wen;
		logic [`DC_WORD_W-1:0] addr;
		logic [`DC_WORD_W-1:0] store;
	} memReq;

	typedef struct packed {
		logic                  memWait;
		logic [`DC_WORD_W-1:0] load;
	} memResp;

	// Tag array update command from the controller
	typedef struct packed {
		logic                  way;
		logic [`DC_IDX_W-1:0]  set;
		logic [`DC_TAG_W-1:0]  tag;
		logic                  setValid;
		logic                  setDirty;
		logic                  clrDirty;
		logic                  touch;
	} tagWrite;

	typedef enum logic [3:0] {
		stIdle,
		stReadHit,
		stWriteHit,
		stOverwrite,
		stCleanA,
		stCleanB,
		stFetchA,
		stFetchB,
		stFlush,
		stStop
	} ctrlState;

endpackage

//--- dcache_defines.svh
// Data cache geometry and field widths
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Word and address width
`define DC_WORD_W 32

// Set index, 16 sets
`define DC_IDX_W 4
`define DC_SETS 16

// Tag is what is left after index, block offset and byte offset
`define DC_TAG_W 25

// Byte offset inside a word
`define DC_BYTOFF_W 2

// Address step from word A to word B of a block
`define DC_WORD_BYTES 4

`endif
